/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module tb_fir -o tb_fir
	./obj_dir/tb_fir | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
fir_pkg.sv
fir_axil_regs.sv
fir_sample_buffer.sv
fir_mac.sv
fir_stream_out.sv
fir_mem_mux.sv
fir_top.sv
fir_checker.sv
tb_fir.sv

/* fir_axil_regs.sv */
`timescale 1ns/1ps

module fir_axil_regs import fir_pkg::*; (
	input  logic              axis_clk,
	input  logic              axis_rst_n,
	input  logic              i_awvalid,
	input  logic [ADDR_W-1:0] i_awaddr,
	output logic              o_awready,
	input  logic              i_wvalid,
	input  word_t             i_wdata,
	output logic              o_wready,
	input  logic              i_arvalid,
	input  logic [ADDR_W-1:0] i_araddr,
	output logic              o_arready,
	output logic              o_rvalid,
	input  logic              i_rready,
	output word_t             o_rdata,
	input  word_t             i_tap_rdata,
	input  logic              i_busy,
	input  logic              i_done,
	output logic              o_ap_start,
	output ram_req_t          o_coef_req
);

	axil_wr_state_t    wr_state, wr_next;
	axil_rd_state_t    rd_state, rd_next;
	logic [ADDR_W-1:0] wr_addr;
	word_t             wr_data;
	logic [ADDR_W-1:0] rd_addr;
	word_t             data_len;
	logic              done_q;
	logic              wr_fire;
	logic              rd_fire;
	logic              wr_commit;
	logic              start_hit;
	word_t             ctrl_word;

	function automatic logic is_coef(input logic [ADDR_W-1:0] addr);
		return (addr >= ADDR_COEF_BASE) && (addr <= ADDR_COEF_LAST);
	endfunction

	// tap RAM byte address of coefficient k
	function automatic logic [ADDR_W-1:0] coef_addr(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] k;
		k = (addr - ADDR_COEF_BASE) >> BYTE_SHIFT;
		return k << BYTE_SHIFT;
	endfunction

	////////////////////////////////////////
	// write channel
	////////////////////////////////////////
	assign wr_fire   = i_awvalid && i_wvalid && o_awready && o_wready;
	assign wr_commit = (wr_state == WR_ACCEPT);

	always_comb begin
		wr_next = wr_state;
		case (wr_state)
			WR_IDLE: begin
				if (wr_fire)
					wr_next = WR_ACCEPT;
			end
			WR_ACCEPT: wr_next = WR_COMMIT;
			WR_COMMIT: wr_next = WR_IDLE;
			default:   wr_next = WR_IDLE;
		endcase
	end

	always_ff @(posedge axis_clk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			wr_state  <= WR_IDLE;
			o_awready <= 1'b0;
			o_wready  <= 1'b0;
		end else begin
			wr_state  <= wr_next;
			o_awready <= (wr_next == WR_IDLE);
			o_wready  <= (wr_next == WR_IDLE);
		end
	end

	always_ff @(posedge axis_clk) begin
		if (wr_fire) begin
			wr_addr <= i_awaddr;
			wr_data <= i_wdata;
		end
	end

	// start is dropped while a run is in progress
	assign start_hit = wr_commit && (wr_addr == ADDR_AP_CTRL) && wr_data[0] && !i_busy;

	always_ff @(posedge axis_clk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			o_ap_start <= 1'b0;
			done_q     <= 1'b0;
			data_len   <= '0;
		end else begin
			o_ap_start <= start_hit;
			if (start_hit)
				done_q <= 1'b0;
			else if (i_done)
				done_q <= 1'b1;
			if (wr_commit && (wr_addr == ADDR_DATA_LEN))
				data_len <= wr_data;
		end
	end

	////////////////////////////////////////
	// read channel
	////////////////////////////////////////
	assign rd_fire = i_arvalid && o_arready;

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			RD_IDLE: begin
				if (rd_fire)
					rd_next = RD_ACCESS;
			end
			RD_ACCESS:   rd_next = RD_WAIT_MEM;
			// RAM output is valid from here on
			RD_WAIT_MEM: rd_next = i_rready ? RD_IDLE : RD_RESPOND;
			RD_RESPOND: begin
				if (i_rready)
					rd_next = RD_IDLE;
			end
			default:     rd_next = RD_IDLE;
		endcase
	end

	always_ff @(posedge axis_clk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			rd_state  <= RD_IDLE;
			o_arready <= 1'b0;
		end else begin
			rd_state  <= rd_next;
			o_arready <= (rd_next == RD_IDLE);
		end
	end

	always_ff @(posedge axis_clk) begin
		if (rd_fire)
			rd_addr <= i_araddr;
	end

	assign o_rvalid  = (rd_state == RD_WAIT_MEM) || (rd_state == RD_RESPOND);
	// done also shows in the cycle of the pulse itself
	assign ctrl_word = {{(DATA_W-3){1'b0}}, !i_busy, done_q | i_done, o_ap_start};

	always_comb begin
		o_rdata = '0;
		if (o_rvalid) begin
			if (is_coef(rd_addr))
				o_rdata = i_tap_rdata;
			else if (rd_addr == ADDR_AP_CTRL)
				o_rdata = ctrl_word;
			else if (rd_addr == ADDR_DATA_LEN)
				o_rdata = data_len;
		end
	end

	// coefficient writes and reads both go through the tap RAM
	always_comb begin
		o_coef_req = RAM_REQ_IDLE;
		if (wr_commit && is_coef(wr_addr)) begin
			o_coef_req.en    = 1'b1;
			o_coef_req.we    = 4'hf;
			o_coef_req.addr  = coef_addr(wr_addr);
			o_coef_req.wdata = wr_data;
		end else if ((rd_state == RD_ACCESS) && is_coef(rd_addr)) begin
			o_coef_req.en    = 1'b1;
			o_coef_req.addr  = coef_addr(rd_addr);
		end
	end

endmodule

/* fir_checker.sv */
`timescale 1ns/1ps

module fir_checker import fir_pkg::*; (
	input  logic              axis_clk,
	input  logic              axis_rst_n,
	input  logic              i_awvalid,
	input  logic [ADDR_W-1:0] i_awaddr,
	input  logic              i_awready,
	input  logic              i_wvalid,
	input  word_t             i_wdata,
	input  logic              i_wready,
	input  logic              i_arvalid,
	input  logic [ADDR_W-1:0] i_araddr,
	input  logic              i_arready,
	input  logic              i_rvalid,
	input  logic              i_rready,
	input  word_t             i_rdata,
	input  logic              i_ss_tvalid,
	input  word_t             i_ss_tdata,
	input  logic              i_ss_tlast,
	input  logic              i_ss_tready,
	input  logic              i_sm_tvalid,
	input  word_t             i_sm_tdata,
	input  logic              i_sm_tlast,
	input  logic              i_sm_tready,
	output int                o_errors,
	output int                o_checks,
	output int                o_outputs
);

	localparam int LATENCY = 2*NUM_TAPS + 3;

	word_t             coef [NUM_TAPS];
	word_t             xs [$];
	logic              lasts [$];
	word_t             exp_len;
	logic              exp_busy;
	logic              exp_done;
	logic [ADDR_W-1:0] rd_addr;
	int                out_idx;
	word_t             exp_y;
	word_t             exp_rd;
	int                cycle;
	int                accept_cycle;
	logic              prev_tvalid;
	logic              hold_pending;
	word_t             hold_data;
	logic              hold_last;

	// y[n] = sum of h[k] * x[n-k] with samples before the run as zero
	function automatic word_t fir_ref(input int n);
		word_t acc;
		int    k;
		acc = '0;
		for (k = 0; k < NUM_TAPS; k++) begin
			if (n - k >= 0)
				acc = acc + coef[k] * xs[n - k];
		end
		return acc;
	endfunction

	function automatic word_t expected_reg(input logic [ADDR_W-1:0] addr);
		if ((addr >= ADDR_COEF_BASE) && (addr <= ADDR_COEF_LAST))
			return coef[(addr - ADDR_COEF_BASE) >> BYTE_SHIFT];
		if (addr == ADDR_AP_CTRL)
			return {{(DATA_W-3){1'b0}}, !exp_busy, exp_done, 1'b0};
		if (addr == ADDR_DATA_LEN)
			return exp_len;
		return '0;
	endfunction

	always @(posedge axis_clk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			exp_len      = '0;
			exp_busy     = 1'b0;
			exp_done     = 1'b0;
			out_idx      = 0;
			o_errors     = 0;
			o_checks     = 0;
			o_outputs    = 0;
			cycle        = 0;
			accept_cycle = 0;
			prev_tvalid  = 1'b0;
			hold_pending = 1'b0;
			xs.delete();
			lasts.delete();
		end else begin
			cycle++;
			// read response first since it shows the status before this edge
			if (i_rvalid && i_rready) begin
				o_checks++;
				exp_rd = expected_reg(rd_addr);
				if (i_rdata !== exp_rd) begin
					o_errors++;
					$display("ERROR %0t: read of 0x%03h gave %h, expected %h",
						$time, rd_addr, i_rdata, exp_rd);
				end
			end
			if (i_arvalid && i_arready)
				rd_addr = i_araddr;

			////////////////////////////////////////
			// register writes
			////////////////////////////////////////
			if (i_awvalid && i_awready && i_wvalid && i_wready) begin
				if ((i_awaddr >= ADDR_COEF_BASE) && (i_awaddr <= ADDR_COEF_LAST))
					coef[(i_awaddr - ADDR_COEF_BASE) >> BYTE_SHIFT] = i_wdata;
				else if (i_awaddr == ADDR_DATA_LEN)
					exp_len = i_wdata;
				else if ((i_awaddr == ADDR_AP_CTRL) && i_wdata[0] && !exp_busy) begin
					// new run starts with an empty history
					exp_busy = 1'b1;
					exp_done = 1'b0;
					out_idx  = 0;
					xs.delete();
					lasts.delete();
				end
			end

			if (i_ss_tvalid && i_ss_tready) begin
				xs.push_back(i_ss_tdata);
				lasts.push_back(i_ss_tlast);
				accept_cycle = cycle;
			end

			////////////////////////////////////////
			// results
			////////////////////////////////////////
			if (i_sm_tvalid && !prev_tvalid) begin
				o_checks++;
				if (cycle - accept_cycle != LATENCY) begin
					o_errors++;
					$display("ERROR %0t: output %0d came %0d cycles after its sample, expected %0d",
						$time, out_idx, cycle - accept_cycle, LATENCY);
				end
			end

			// a stalled result keeps its word and its tlast
			if (hold_pending) begin
				o_checks++;
				if (!i_sm_tvalid || (i_sm_tdata !== hold_data) ||
				    (i_sm_tlast !== hold_last)) begin
					o_errors++;
					$display("ERROR %0t: stalled output %h last %b became %h last %b valid %b",
						$time, hold_data, hold_last, i_sm_tdata, i_sm_tlast, i_sm_tvalid);
				end
			end

			if (i_sm_tvalid && i_ss_tready) begin
				o_errors++;
				$display("ERROR %0t: ss_tready is high while an output is pending", $time);
			end

			if (i_sm_tvalid && i_sm_tready) begin
				o_outputs++;
				if (out_idx >= xs.size()) begin
					o_errors++;
					$display("ERROR %0t: output %h with no sample pending", $time, i_sm_tdata);
				end else begin
					o_checks++;
					exp_y = fir_ref(out_idx);
					if ((i_sm_tdata !== exp_y) || (i_sm_tlast !== lasts[out_idx])) begin
						o_errors++;
						$display("ERROR %0t: output %0d is %h last %b, expected %h last %b",
							$time, out_idx, i_sm_tdata, i_sm_tlast, exp_y, lasts[out_idx]);
					end
					if (lasts[out_idx]) begin
						exp_busy = 1'b0;
						exp_done = 1'b1;
					end
				end
				out_idx++;
			end

			hold_pending = i_sm_tvalid && !i_sm_tready;
			hold_data    = i_sm_tdata;
			hold_last    = i_sm_tlast;
			prev_tvalid  = i_sm_tvalid;
		end
	end

endmodule

/* fir_mac.sv */
`timescale 1ns/1ps

module fir_mac import fir_pkg::*; (
	input  logic     axis_clk,
	input  logic     axis_rst_n,
	input  logic     i_sample_go,
	input  idx_t     i_head,
	input  logic     i_last_flag,
	input  word_t    i_tap_rdata,
	input  word_t    i_data_rdata,
	output ram_req_t o_tap_req,
	output ram_req_t o_data_req,
	output logic     o_y_valid,
	output word_t    o_y,
	output logic     o_y_last
);

	mac_state_t state, state_next;
	idx_t       tap_idx;
	idx_t       pos;
	word_t      acc;
	word_t      product;
	logic       last_tap;

	assign last_tap = (tap_idx == idx_t'(NUM_TAPS-1));
	// low 32 bits only, wrapping like the accumulator
	assign product  = i_tap_rdata * i_data_rdata;

	always_comb begin
		state_next = state;
		case (state)
			MAC_IDLE: begin
				if (i_sample_go)
					state_next = MAC_ISSUE;
			end
			MAC_ISSUE: state_next = MAC_ACCUM;
			MAC_ACCUM: state_next = last_tap ? MAC_EMIT : MAC_ISSUE;
			MAC_EMIT:  state_next = MAC_IDLE;
			default:   state_next = MAC_IDLE;
		endcase
	end

	always_ff @(posedge axis_clk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			state    <= MAC_IDLE;
			tap_idx  <= '0;
			pos      <= '0;
			o_y_last <= 1'b0;
		end else begin
			state <= state_next;
			if ((state == MAC_IDLE) && i_sample_go) begin
				tap_idx  <= '0;
				pos      <= i_head;
				o_y_last <= i_last_flag;
			end else if ((state == MAC_ACCUM) && !last_tap) begin
				tap_idx <= tap_idx + 1'b1;
				// walk back through the ring, oldest sample last
				pos     <= (pos == '0) ? idx_t'(NUM_TAPS-1) : pos - 1'b1;
			end
		end
	end

	always_ff @(posedge axis_clk) begin
		if ((state == MAC_IDLE) && i_sample_go)
			acc <= '0;
		else if (state == MAC_ACCUM)
			acc <= acc + product;
	end

	////////////////////////////////////////
	// RAM reads with data back one cycle later
	////////////////////////////////////////
	always_comb begin
		o_tap_req  = RAM_REQ_IDLE;
		o_data_req = RAM_REQ_IDLE;
		if (state == MAC_ISSUE) begin
			o_tap_req.en    = 1'b1;
			o_tap_req.addr  = ADDR_W'(tap_idx) << BYTE_SHIFT;
			o_data_req.en   = 1'b1;
			o_data_req.addr = ADDR_W'(pos) << BYTE_SHIFT;
		end
	end

	assign o_y_valid = (state == MAC_EMIT);
	assign o_y       = acc;

endmodule

/* fir_mem_mux.sv */
`timescale 1ns/1ps

module fir_mem_mux import fir_pkg::*; (
	input  logic     i_busy,
	input  ram_req_t i_coef_req,
	input  ram_req_t i_buf_req,
	input  ram_req_t i_mac_tap_req,
	input  ram_req_t i_mac_data_req,
	output ram_req_t o_tap_req,
	output ram_req_t o_data_req
);

	// tap RAM belongs to the engine during a run
	assign o_tap_req = i_busy ? i_mac_tap_req : i_coef_req;

	// MAC reads and buffer writes never overlap
	assign o_data_req = i_mac_data_req.en ? i_mac_data_req : i_buf_req;

endmodule

/* fir_pkg.sv */
package fir_pkg;

	////////////////////////////////////////
	// sizes
	////////////////////////////////////////
	localparam int DATA_W     = 32;
	localparam int ADDR_W     = 12;
	localparam int NUM_TAPS   = 11;
	localparam int IDX_W      = 4;
	// word index to byte address
	localparam int BYTE_SHIFT = 2;

	////////////////////////////////////////
	// register map
	////////////////////////////////////////
	localparam logic [ADDR_W-1:0] ADDR_AP_CTRL   = 12'h000;
	localparam logic [ADDR_W-1:0] ADDR_DATA_LEN  = 12'h010;
	localparam logic [ADDR_W-1:0] ADDR_COEF_BASE = 12'h040;
	localparam logic [ADDR_W-1:0] ADDR_COEF_LAST = 12'h068;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [IDX_W-1:0]  idx_t;

	typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_COMMIT} axil_wr_state_t;
	typedef enum logic [1:0] {RD_IDLE, RD_ACCESS, RD_WAIT_MEM, RD_RESPOND} axil_rd_state_t;
	typedef enum logic [2:0] {
		BUF_IDLE,
		BUF_CLEAR,
		BUF_WAIT_SAMPLE,
		BUF_BUSY,
		BUF_FINISHED
	} buf_state_t;
	typedef enum logic [1:0] {MAC_IDLE, MAC_ISSUE, MAC_ACCUM, MAC_EMIT} mac_state_t;

	// one access to a single-port block RAM
	typedef struct packed {
		logic              en;
		logic [3:0]        we;
		logic [ADDR_W-1:0] addr;
		word_t             wdata;
	} ram_req_t;

	localparam ram_req_t RAM_REQ_IDLE = '0;

endpackage

/* fir_sample_buffer.sv */
`timescale 1ns/1ps

module fir_sample_buffer import fir_pkg::*; (
	input  logic     axis_clk,
	input  logic     axis_rst_n,
	input  logic     i_ap_start,
	input  logic     i_ss_tvalid,
	input  word_t    i_ss_tdata,
	input  logic     i_ss_tlast,
	input  logic     i_y_taken,
	output logic     o_ss_tready,
	output logic     o_busy,
	output logic     o_done,
	output logic     o_sample_go,
	output idx_t     o_head,
	output logic     o_last_flag,
	output ram_req_t o_buf_req
);

	buf_state_t state, state_next;
	idx_t       clr_idx;
	idx_t       wr_ptr;
	logic       accept;
	logic       start_run;

	assign o_ss_tready = (state == BUF_WAIT_SAMPLE);
	assign accept      = o_ss_tready && i_ss_tvalid;
	assign o_busy      = (state == BUF_CLEAR) || (state == BUF_WAIT_SAMPLE) ||
	                     (state == BUF_BUSY);
	assign o_done      = (state == BUF_FINISHED);
	assign start_run   = i_ap_start && !o_busy;

	always_comb begin
		state_next = state;
		case (state)
			BUF_IDLE: begin
				if (start_run)
					state_next = BUF_CLEAR;
			end
			BUF_CLEAR: begin
				if (clr_idx == idx_t'(NUM_TAPS-1))
					state_next = BUF_WAIT_SAMPLE;
			end
			BUF_WAIT_SAMPLE: begin
				if (accept)
					state_next = BUF_BUSY;
			end
			// one sample in flight until its result leaves
			BUF_BUSY: begin
				if (i_y_taken)
					state_next = o_last_flag ? BUF_FINISHED : BUF_WAIT_SAMPLE;
			end
			BUF_FINISHED: state_next = start_run ? BUF_CLEAR : BUF_IDLE;
			default:      state_next = BUF_IDLE;
		endcase
	end

	always_ff @(posedge axis_clk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			state       <= BUF_IDLE;
			clr_idx     <= '0;
			wr_ptr      <= '0;
			o_head      <= '0;
			o_last_flag <= 1'b0;
			o_sample_go <= 1'b0;
		end else begin
			state       <= state_next;
			o_sample_go <= accept;
			if (start_run) begin
				clr_idx     <= '0;
				wr_ptr      <= '0;
				o_last_flag <= 1'b0;
			end else if (state == BUF_CLEAR) begin
				clr_idx <= clr_idx + 1'b1;
			end
			// ring of NUM_TAPS words
			if (accept) begin
				o_head      <= wr_ptr;
				o_last_flag <= i_ss_tlast;
				wr_ptr      <= (wr_ptr == idx_t'(NUM_TAPS-1)) ? '0 : wr_ptr + 1'b1;
			end
		end
	end

	always_comb begin
		o_buf_req = RAM_REQ_IDLE;
		if (state == BUF_CLEAR) begin
			o_buf_req.en   = 1'b1;
			o_buf_req.we   = 4'hf;
			o_buf_req.addr = ADDR_W'(clr_idx) << BYTE_SHIFT;
		end else if (accept) begin
			o_buf_req.en    = 1'b1;
			o_buf_req.we    = 4'hf;
			o_buf_req.addr  = ADDR_W'(wr_ptr) << BYTE_SHIFT;
			o_buf_req.wdata = i_ss_tdata;
		end
	end

endmodule

/* fir_stream_out.sv */
`timescale 1ns/1ps

module fir_stream_out import fir_pkg::*; (
	input  logic  axis_clk,
	input  logic  axis_rst_n,
	input  logic  i_y_valid,
	input  word_t i_y,
	input  logic  i_y_last,
	input  logic  i_sm_tready,
	output logic  o_sm_tvalid,
	output word_t o_sm_tdata,
	output logic  o_sm_tlast,
	output logic  o_y_taken
);

	assign o_y_taken = o_sm_tvalid && i_sm_tready;

	// new result only arrives after the previous one has left
	always_ff @(posedge axis_clk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			o_sm_tvalid <= 1'b0;
			o_sm_tlast  <= 1'b0;
		end else if (i_y_valid) begin
			o_sm_tvalid <= 1'b1;
			o_sm_tlast  <= i_y_last;
		end else if (o_y_taken) begin
			o_sm_tvalid <= 1'b0;
			o_sm_tlast  <= 1'b0;
		end
	end

	always_ff @(posedge axis_clk) begin
		if (i_y_valid)
			o_sm_tdata <= i_y;
	end

endmodule

/* fir_top.sv */
`timescale 1ns/1ps

module fir_top import fir_pkg::*; (
	input  logic              axis_clk,
	input  logic              axis_rst_n,
	// register port
	input  logic              i_awvalid,
	input  logic [ADDR_W-1:0] i_awaddr,
	output logic              o_awready,
	input  logic              i_wvalid,
	input  word_t             i_wdata,
	output logic              o_wready,
	input  logic              i_arvalid,
	input  logic [ADDR_W-1:0] i_araddr,
	output logic              o_arready,
	output logic              o_rvalid,
	input  logic              i_rready,
	output word_t             o_rdata,
	// streams
	input  logic              i_ss_tvalid,
	input  word_t             i_ss_tdata,
	input  logic              i_ss_tlast,
	output logic              o_ss_tready,
	input  logic              i_sm_tready,
	output logic              o_sm_tvalid,
	output word_t             o_sm_tdata,
	output logic              o_sm_tlast,
	// tap RAM
	output logic [3:0]        o_tap_we,
	output logic              o_tap_en,
	output word_t             o_tap_di,
	output logic [ADDR_W-1:0] o_tap_a,
	input  word_t             i_tap_do,
	// data RAM
	output logic [3:0]        o_data_we,
	output logic              o_data_en,
	output word_t             o_data_di,
	output logic [ADDR_W-1:0] o_data_a,
	input  word_t             i_data_do
);

	logic     ap_start, busy, done;
	logic     sample_go, last_flag;
	idx_t     head;
	logic     y_valid, y_last, y_taken;
	word_t    y;
	ram_req_t coef_req, buf_req, mac_tap_req, mac_data_req;
	ram_req_t tap_req, data_req;

	fir_axil_regs regs_i (
		.axis_clk, .axis_rst_n,
		.i_awvalid, .i_awaddr, .o_awready, .i_wvalid, .i_wdata, .o_wready,
		.i_arvalid, .i_araddr, .o_arready, .o_rvalid, .i_rready, .o_rdata,
		.i_tap_rdata (i_tap_do),
		.i_busy      (busy),
		.i_done      (done),
		.o_ap_start  (ap_start),
		.o_coef_req  (coef_req)
	);

	fir_sample_buffer buf_i (
		.axis_clk, .axis_rst_n,
		.i_ap_start  (ap_start),
		.i_ss_tvalid, .i_ss_tdata, .i_ss_tlast,
		.i_y_taken   (y_taken),
		.o_ss_tready,
		.o_busy      (busy),
		.o_done      (done),
		.o_sample_go (sample_go),
		.o_head      (head),
		.o_last_flag (last_flag),
		.o_buf_req   (buf_req)
	);

	fir_mac mac_i (
		.axis_clk, .axis_rst_n,
		.i_sample_go  (sample_go),
		.i_head       (head),
		.i_last_flag  (last_flag),
		.i_tap_rdata  (i_tap_do),
		.i_data_rdata (i_data_do),
		.o_tap_req    (mac_tap_req),
		.o_data_req   (mac_data_req),
		.o_y_valid    (y_valid),
		.o_y          (y),
		.o_y_last     (y_last)
	);

	fir_stream_out out_i (
		.axis_clk, .axis_rst_n,
		.i_y_valid (y_valid),
		.i_y       (y),
		.i_y_last  (y_last),
		.i_sm_tready, .o_sm_tvalid, .o_sm_tdata, .o_sm_tlast,
		.o_y_taken (y_taken)
	);

	fir_mem_mux mux_i (
		.i_busy         (busy),
		.i_coef_req     (coef_req),
		.i_buf_req      (buf_req),
		.i_mac_tap_req  (mac_tap_req),
		.i_mac_data_req (mac_data_req),
		.o_tap_req      (tap_req),
		.o_data_req     (data_req)
	);

	////////////////////////////////////////
	// RAM pins
	////////////////////////////////////////
	assign o_tap_en  = tap_req.en;
	assign o_tap_we  = tap_req.we;
	assign o_tap_a   = tap_req.addr;
	assign o_tap_di  = tap_req.wdata;
	assign o_data_en = data_req.en;
	assign o_data_we = data_req.we;
	assign o_data_a  = data_req.addr;
	assign o_data_di = data_req.wdata;

endmodule

/* tb_fir.sv */
`timescale 1ns/1ps

module tb_fir import fir_pkg::*; ();

	localparam int NUM_SAMPLES = 64;
	localparam int NUM_RUNS    = 2;
	localparam int MAX_STALL   = 4;
	localparam int SEED        = 13643;
	// latency, stall and input handshake per sample, plus register traffic
	localparam int CYCLE_LIMIT = NUM_RUNS * NUM_SAMPLES *
	                             (2*NUM_TAPS + 3 + MAX_STALL + 4) + 2000;

	logic              axis_clk;
	logic              axis_rst_n;
	logic              awvalid, wvalid, arvalid, rready;
	logic              awready, wready, arready, rvalid;
	logic [ADDR_W-1:0] awaddr, araddr;
	word_t             wdata, rdata;
	logic              ss_tvalid, ss_tlast, ss_tready;
	logic              sm_tvalid, sm_tlast, sm_tready;
	word_t             ss_tdata, sm_tdata;
	logic [3:0]        tap_we, data_we;
	logic              tap_en, data_en;
	logic [ADDR_W-1:0] tap_a, data_a;
	word_t             tap_di, data_di;
	word_t             tap_do = '0;
	word_t             data_do = '0;
	word_t             tap_mem [0:1023];
	word_t             data_mem [0:1023];
	int                chk_errors, chk_checks, chk_outputs;
	int                count_errors = 0;
	int                cycles = 0;
	int                stall_left = 0;

	fir_top dut_i (
		.axis_clk (axis_clk), .axis_rst_n (axis_rst_n),
		.i_awvalid (awvalid), .i_awaddr (awaddr), .o_awready (awready),
		.i_wvalid (wvalid), .i_wdata (wdata), .o_wready (wready),
		.i_arvalid (arvalid), .i_araddr (araddr), .o_arready (arready),
		.o_rvalid (rvalid), .i_rready (rready), .o_rdata (rdata),
		.i_ss_tvalid (ss_tvalid), .i_ss_tdata (ss_tdata), .i_ss_tlast (ss_tlast),
		.o_ss_tready (ss_tready), .i_sm_tready (sm_tready), .o_sm_tvalid (sm_tvalid),
		.o_sm_tdata (sm_tdata), .o_sm_tlast (sm_tlast),
		.o_tap_we (tap_we), .o_tap_en (tap_en), .o_tap_di (tap_di), .o_tap_a (tap_a),
		.i_tap_do (tap_do),
		.o_data_we (data_we), .o_data_en (data_en), .o_data_di (data_di),
		.o_data_a (data_a), .i_data_do (data_do)
	);

	fir_checker chk_i (
		.axis_clk, .axis_rst_n,
		.i_awvalid (awvalid), .i_awaddr (awaddr), .i_awready (awready),
		.i_wvalid (wvalid), .i_wdata (wdata), .i_wready (wready),
		.i_arvalid (arvalid), .i_araddr (araddr), .i_arready (arready),
		.i_rvalid (rvalid), .i_rready (rready), .i_rdata (rdata),
		.i_ss_tvalid (ss_tvalid), .i_ss_tdata (ss_tdata), .i_ss_tlast (ss_tlast),
		.i_ss_tready (ss_tready), .i_sm_tvalid (sm_tvalid), .i_sm_tdata (sm_tdata),
		.i_sm_tlast (sm_tlast), .i_sm_tready (sm_tready),
		.o_errors (chk_errors), .o_checks (chk_checks), .o_outputs (chk_outputs)
	);

	initial axis_clk = 1'b0;
	always #50 axis_clk = ~axis_clk;

	////////////////////////////////////////
	// block RAM models with one cycle of read latency
	////////////////////////////////////////
	always @(posedge axis_clk) begin
		if (tap_en) begin
			if (|tap_we)
				tap_mem[tap_a[ADDR_W-1:BYTE_SHIFT]] <= tap_di;
			tap_do <= tap_mem[tap_a[ADDR_W-1:BYTE_SHIFT]];
		end
	end

	always @(posedge axis_clk) begin
		if (data_en) begin
			if (|data_we)
				data_mem[data_a[ADDR_W-1:BYTE_SHIFT]] <= data_di;
			data_do <= data_mem[data_a[ADDR_W-1:BYTE_SHIFT]];
		end
	end

	// output back-pressure of 1 to MAX_STALL low cycles at a time
	always @(negedge axis_clk) begin
		if (stall_left > 0) begin
			sm_tready = 1'b0;
			stall_left = stall_left - 1;
		end else begin
			sm_tready = 1'b1;
			if ($urandom_range(3, 0) == 0)
				stall_left = $urandom_range(MAX_STALL, 1);
		end
	end

	always @(posedge axis_clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input word_t data);
		@(negedge axis_clk);
		awvalid = 1'b1;
		awaddr  = addr;
		wvalid  = 1'b1;
		wdata   = data;
		while (!(awready && wready))
			@(negedge axis_clk);
		@(negedge axis_clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] addr, output word_t data);
		@(negedge axis_clk);
		arvalid = 1'b1;
		araddr  = addr;
		while (!arready)
			@(negedge axis_clk);
		@(negedge axis_clk);
		arvalid = 1'b0;
		rready  = 1'b1;
		while (!rvalid)
			@(negedge axis_clk);
		data = rdata;
		@(negedge axis_clk);
		rready = 1'b0;
	endtask

	// tlast only on the final sample of the run
	task automatic send_samples(input int count);
		int i;
		@(negedge axis_clk);
		for (i = 0; i < count; i++) begin
			ss_tvalid = 1'b1;
			ss_tdata  = $urandom();
			ss_tlast  = (i == count - 1);
			while (!ss_tready)
				@(negedge axis_clk);
			@(negedge axis_clk);
		end
		ss_tvalid = 1'b0;
		ss_tlast  = 1'b0;
	endtask

	task automatic wait_for_done();
		word_t status;
		status = '0;
		while (!status[1])
			read_reg(ADDR_AP_CTRL, status);
	endtask

	initial begin
		word_t rd;
		int    k;
		int    run;
		axis_rst_n = 1'b0;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b0;
		ss_tvalid  = 1'b0;
		ss_tdata   = '0;
		ss_tlast   = 1'b0;
		sm_tready  = 1'b0;
		void'($urandom(SEED));
		repeat (3) @(posedge axis_clk);
		@(negedge axis_clk);
		axis_rst_n = 1'b1;

		// idle after reset
		read_reg(ADDR_AP_CTRL, rd);
		write_reg(ADDR_DATA_LEN, NUM_SAMPLES);
		for (k = 0; k < NUM_TAPS; k++)
			write_reg(ADDR_COEF_BASE + ADDR_W'(k << BYTE_SHIFT), $urandom());
		for (k = 0; k < NUM_TAPS; k++)
			read_reg(ADDR_COEF_BASE + ADDR_W'(k << BYTE_SHIFT), rd);
		read_reg(ADDR_DATA_LEN, rd);

		////////////////////////////////////////
		// two runs where the second restarts history
		////////////////////////////////////////
		for (run = 0; run < NUM_RUNS; run++) begin
			write_reg(ADDR_AP_CTRL, 32'h1);
			read_reg(ADDR_AP_CTRL, rd);
			send_samples(NUM_SAMPLES);
			wait_for_done();
			read_reg(ADDR_AP_CTRL, rd);
		end

		if (chk_outputs != NUM_RUNS * NUM_SAMPLES) begin
			count_errors++;
			$display("wrong number of results: got %0d, expected %0d",
				chk_outputs, NUM_RUNS * NUM_SAMPLES);
		end
		$display("checks: %0d, errors: %0d", chk_checks, chk_errors + count_errors);
		if (chk_errors + count_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
